// File: Bender.yml
package:
  name: bpu

sources:
  - design/bpu_isa_pkg.sv
  - design/bpu_pred_pkg.sv
  - design/branch_predecoder.sv
  - design/target_buffer.sv
  - design/direction_chooser.sv
  - design/branch_resolver.sv
  - design/branch_predict_unit.sv
  - target: test
    files:
      - tests/bpu_properties.sv
      - tests/bpu_checker.sv
      - tests/bpu_tb.sv

// File: bpu.f
design/bpu_isa_pkg.sv
design/bpu_pred_pkg.sv
design/branch_predecoder.sv
design/target_buffer.sv
design/direction_chooser.sv
design/branch_resolver.sv
design/branch_predict_unit.sv
tests/bpu_properties.sv
tests/bpu_checker.sv
tests/bpu_tb.sv

// File: design/bpu_isa_pkg.sv
package bpu_isa_pkg;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  opc_t;  // inst[31:28]

    // branch type from the pre-decoder
    typedef logic [1:0] btype_t;

    localparam btype_t BT_NONE     = 2'b00;
    localparam btype_t BT_JUMP     = 2'b01;  // direct, unconditional
    localparam btype_t BT_COND     = 2'b10;  // pc relative
    localparam btype_t BT_INDIRECT = 2'b11;  // unconditional too

    // opcodes that map to a branch type, everything else is no branch
    localparam opc_t OPC_JUMP     = 4'b1100;
    localparam opc_t OPC_COND     = 4'b1101;
    localparam opc_t OPC_INDIRECT = 4'b1110;

    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;

    // fetch group is two words
    localparam pc_t FETCH_BYTES = 32'd8;

endpackage

// File: design/bpu_pred_pkg.sv
package bpu_pred_pkg;

    // taken states have bit 0 clear
    typedef enum logic [1:0] {
        CTR_STRONG_TAKEN    = 2'b00,
        CTR_STRONG_NOTTAKEN = 2'b01,
        CTR_WEAK_TAKEN      = 2'b10,
        CTR_WEAK_NOTTAKEN   = 2'b11
    } ctr_e;

    typedef enum logic [1:0] {
        SEL_IDLE = 2'b00,  // static not taken
        SEL_EASY = 2'b01,
        SEL_HARD = 2'b10
    } sel_e;

    typedef logic [1:0] score_t;

    typedef struct packed {
        logic                strobe;
        bpu_isa_pkg::pc_t    pc;
        bpu_isa_pkg::btype_t btype;
    } lookup_s;

    typedef struct packed {
        logic             strobe;
        logic             taken;
        bpu_isa_pkg::pc_t pc;
    } pred_s;

    typedef struct packed {
        logic                strobe;
        bpu_isa_pkg::pc_t    pc;
        bpu_isa_pkg::btype_t btype;
        logic                taken;       // actual outcome
        bpu_isa_pkg::pc_t    target;      // actual target
        logic                pred_taken;
        bpu_isa_pkg::pc_t    pred_pc;
    } resolve_s;

    typedef struct packed {
        logic             strobe;
        bpu_isa_pkg::pc_t pc;
        logic             cond;     // conditional branch, trains the chooser
        logic             taken;
        logic             dir_hit;
        logic             wr;       // write target and set valid
        bpu_isa_pkg::pc_t target;
    } update_s;

endpackage

// File: design/branch_predecoder.sv
`timescale 1ns/1ns

module branch_predecoder (
    input  logic                  fetch_valid,
    input  bpu_isa_pkg::pc_t      fetch_pc,
    input  bpu_isa_pkg::inst_t    fetch_inst,
    output bpu_pred_pkg::lookup_s lookup
);

    bpu_isa_pkg::opc_t   opc;
    bpu_isa_pkg::btype_t btype;

    assign opc = fetch_inst[bpu_isa_pkg::OPC_MSB:bpu_isa_pkg::OPC_LSB];

    always_comb begin
        case (opc)
            bpu_isa_pkg::OPC_JUMP: begin
                btype = bpu_isa_pkg::BT_JUMP;
            end
            bpu_isa_pkg::OPC_COND: begin
                btype = bpu_isa_pkg::BT_COND;
            end
            bpu_isa_pkg::OPC_INDIRECT: begin
                btype = bpu_isa_pkg::BT_INDIRECT;
            end
            default: begin
                btype = bpu_isa_pkg::BT_NONE;  // alu, load, store ...
            end
        endcase
    end

    // lookup request for the target buffer
    always_comb begin
        lookup.strobe = fetch_valid;
        lookup.pc     = fetch_pc;
        lookup.btype  = btype;
    end

endmodule

// File: design/branch_predict_unit.sv
`timescale 1ns/1ns

module branch_predict_unit #(
    parameter int INDEX_W = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fetch_valid,
    input  bpu_isa_pkg::pc_t       fetch_pc,
    input  bpu_isa_pkg::inst_t     fetch_inst,
    input  bpu_pred_pkg::resolve_s resolve,
    output bpu_pred_pkg::pred_s    pred,
    output logic                   redirect_valid,
    output bpu_isa_pkg::pc_t       redirect_pc
);

    bpu_pred_pkg::lookup_s lookup;
    bpu_pred_pkg::update_s update;
    logic                  cond_taken;

    branch_predecoder i_branch_predecoder (
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .lookup      (lookup)
    );

    target_buffer #(
        .INDEX_W (INDEX_W)
    ) i_target_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .lookup     (lookup),
        .cond_taken (cond_taken),
        .update     (update),
        .pred       (pred)
    );

    direction_chooser i_direction_chooser (
        .clk        (clk),
        .rstn       (rstn),
        .update     (update),
        .cond_taken (cond_taken)
    );

    branch_resolver i_branch_resolver (
        .clk            (clk),
        .rstn           (rstn),
        .resolve        (resolve),
        .update         (update),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// File: design/branch_resolver.sv
`timescale 1ns/1ns

module branch_resolver (
    input  logic                   clk,
    input  logic                   rstn,
    input  bpu_pred_pkg::resolve_s resolve,
    output bpu_pred_pkg::update_s  update,
    output logic                   redirect_valid,
    output bpu_isa_pkg::pc_t       redirect_pc
);

    logic             dir_fail;
    logic             tgt_fail;
    logic             is_cond;
    bpu_isa_pkg::pc_t fix_pc;

    assign dir_fail = resolve.pred_taken != resolve.taken;
    assign tgt_fail = resolve.taken && (resolve.pred_pc != resolve.target);
    assign is_cond  = resolve.btype == bpu_isa_pkg::BT_COND;

    // correct next pc for the fetch stage
    assign fix_pc = resolve.taken ? resolve.target
                                  : resolve.pc + bpu_isa_pkg::FETCH_BYTES;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            update <= '0;
        end else begin
            update.strobe  <= resolve.strobe;
            update.pc      <= resolve.pc;
            update.cond    <= is_cond;
            update.taken   <= resolve.taken;
            update.dir_hit <= !dir_fail;
            update.wr      <= resolve.taken && tgt_fail;
            update.target  <= resolve.target;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            redirect_valid <= resolve.strobe && (dir_fail || tgt_fail);
            redirect_pc    <= fix_pc;
        end
    end

endmodule

// File: design/direction_chooser.sv
`timescale 1ns/1ns

module direction_chooser (
    input  logic                  clk,
    input  logic                  rstn,
    input  bpu_pred_pkg::update_s update,
    output logic                  cond_taken
);

    bpu_pred_pkg::ctr_e   easy_st;
    bpu_pred_pkg::ctr_e   easy_nxt;
    bpu_pred_pkg::ctr_e   hard_st;
    bpu_pred_pkg::ctr_e   hard_nxt;
    bpu_pred_pkg::score_t score;
    bpu_pred_pkg::score_t score_nxt;
    bpu_pred_pkg::sel_e   sel;
    logic                 train;

    assign train = update.strobe && update.cond;

    // easy machine jumps across on every miss
    always_comb begin
        case (easy_st)
            bpu_pred_pkg::CTR_STRONG_TAKEN,
            bpu_pred_pkg::CTR_WEAK_TAKEN: begin
                easy_nxt = update.taken ? bpu_pred_pkg::CTR_STRONG_TAKEN
                                        : bpu_pred_pkg::CTR_WEAK_NOTTAKEN;
            end
            default: begin
                easy_nxt = !update.taken ? bpu_pred_pkg::CTR_STRONG_NOTTAKEN
                                         : bpu_pred_pkg::CTR_WEAK_TAKEN;
            end
        endcase
    end

    // hard machine, plain saturating counter
    always_comb begin
        case (hard_st)
            bpu_pred_pkg::CTR_STRONG_TAKEN: begin
                hard_nxt = update.taken ? bpu_pred_pkg::CTR_STRONG_TAKEN
                                        : bpu_pred_pkg::CTR_WEAK_TAKEN;
            end
            bpu_pred_pkg::CTR_WEAK_TAKEN: begin
                hard_nxt = update.taken ? bpu_pred_pkg::CTR_STRONG_TAKEN
                                        : bpu_pred_pkg::CTR_WEAK_NOTTAKEN;
            end
            bpu_pred_pkg::CTR_WEAK_NOTTAKEN: begin
                hard_nxt = update.taken ? bpu_pred_pkg::CTR_WEAK_TAKEN
                                        : bpu_pred_pkg::CTR_STRONG_NOTTAKEN;
            end
            default: begin
                hard_nxt = update.taken ? bpu_pred_pkg::CTR_WEAK_NOTTAKEN
                                        : bpu_pred_pkg::CTR_STRONG_NOTTAKEN;
            end
        endcase
    end

    always_comb begin
        case (score)
            2'b00:   score_nxt = update.dir_hit ? 2'b00 : 2'b01;
            2'b01:   score_nxt = update.dir_hit ? 2'b00 : 2'b10;
            2'b10:   score_nxt = update.dir_hit ? 2'b11 : 2'b01;
            default: score_nxt = update.dir_hit ? 2'b11 : 2'b10;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            easy_st <= bpu_pred_pkg::CTR_WEAK_TAKEN;
            hard_st <= bpu_pred_pkg::CTR_WEAK_TAKEN;
            score   <= '0;
            sel     <= bpu_pred_pkg::SEL_IDLE;
        end else if (train) begin
            easy_st <= easy_nxt;
            hard_st <= hard_nxt;
            score   <= score_nxt;
            sel     <= score_nxt[1] ? bpu_pred_pkg::SEL_EASY : bpu_pred_pkg::SEL_HARD;
        end
    end

    always_comb begin
        case (sel)
            bpu_pred_pkg::SEL_EASY: begin
                cond_taken = (easy_st == bpu_pred_pkg::CTR_STRONG_TAKEN) ||
                             (easy_st == bpu_pred_pkg::CTR_WEAK_TAKEN);
            end
            bpu_pred_pkg::SEL_HARD: begin
                cond_taken = (hard_st == bpu_pred_pkg::CTR_STRONG_TAKEN) ||
                             (hard_st == bpu_pred_pkg::CTR_WEAK_TAKEN);
            end
            default: cond_taken = 1'b0;  // idle, never taken
        endcase
    end

endmodule

// File: design/target_buffer.sv
`timescale 1ns/1ns

module target_buffer #(
    parameter int INDEX_W = 8
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  bpu_pred_pkg::lookup_s lookup,
    input  logic                  cond_taken,
    input  bpu_pred_pkg::update_s update,
    output bpu_pred_pkg::pred_s   pred
);

    localparam int DEPTH = 2 ** INDEX_W;

    logic [DEPTH-1:0]   valid_mask;
    bpu_isa_pkg::pc_t   tgt_mem [DEPTH];

    logic [INDEX_W-1:0] fetch_idx;
    logic [INDEX_W-1:0] upd_idx;
    logic               we;
    logic               clr;
    logic               taken;
    bpu_isa_pkg::pc_t   fall_pc;
    bpu_isa_pkg::pc_t   nxt_pc;

    assign fetch_idx = lookup.pc[INDEX_W+2:3];
    assign upd_idx   = update.pc[INDEX_W+2:3];
    assign we        = update.strobe && update.wr;
    assign clr       = lookup.strobe && (lookup.btype == bpu_isa_pkg::BT_NONE);
    assign fall_pc   = lookup.pc + bpu_isa_pkg::FETCH_BYTES;

    always_comb begin
        case (lookup.btype)
            bpu_isa_pkg::BT_JUMP,
            bpu_isa_pkg::BT_INDIRECT: taken = 1'b1;
            bpu_isa_pkg::BT_COND:     taken = cond_taken;
            default:                  taken = 1'b0;
        endcase
    end

    // no stored target means fall through even when taken
    assign nxt_pc = (taken && valid_mask[fetch_idx]) ? tgt_mem[fetch_idx] : fall_pc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_mask <= '0;
        end else begin
            if (clr) begin
                valid_mask[fetch_idx] <= 1'b0;
            end
            if (we) begin
                valid_mask[upd_idx] <= 1'b1;  // beats a clear at the same index
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tgt_mem[upd_idx] <= update.target;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pred <= '0;
        end else begin
            pred.strobe <= lookup.strobe;
            pred.taken  <= taken;
            pred.pc     <= nxt_pc;
        end
    end

endmodule

// File: tests/bpu_checker.sv
`timescale 1ns/1ns

module bpu_checker #(
    parameter int INDEX_W = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   fetch_valid,
    input  bpu_isa_pkg::pc_t       fetch_pc,
    input  bpu_isa_pkg::inst_t     fetch_inst,
    input  bpu_pred_pkg::resolve_s resolve,
    input  bpu_pred_pkg::pred_s    pred,
    input  logic                   redirect_valid,
    input  bpu_isa_pkg::pc_t       redirect_pc,
    input  logic [95:0]            test_name,
    output int                     errors
);

    logic [2**INDEX_W-1:0] m_valid;
    bpu_isa_pkg::pc_t      m_tgt [2**INDEX_W];
    int                    easy_lvl;  // 3 strong taken .. 0 strong not taken
    int                    hard_lvl;
    bpu_pred_pkg::score_t  m_score;
    bpu_pred_pkg::sel_e    m_sel;
    bpu_pred_pkg::update_s pend;      // lands one cycle after the resolve
    bpu_pred_pkg::pred_s   exp_pred;
    logic                  exp_redir;
    bpu_isa_pkg::pc_t      exp_redir_pc;

    function automatic bpu_isa_pkg::btype_t btype_of(input bpu_isa_pkg::inst_t inst);
        case (inst[31:28])
            bpu_isa_pkg::OPC_JUMP:     return bpu_isa_pkg::BT_JUMP;
            bpu_isa_pkg::OPC_COND:     return bpu_isa_pkg::BT_COND;
            bpu_isa_pkg::OPC_INDIRECT: return bpu_isa_pkg::BT_INDIRECT;
            default:                   return bpu_isa_pkg::BT_NONE;
        endcase
    endfunction

    function automatic logic cond_guess();
        if (m_sel == bpu_pred_pkg::SEL_EASY) begin
            return easy_lvl >= 2;
        end else if (m_sel == bpu_pred_pkg::SEL_HARD) begin
            return hard_lvl >= 2;
        end
        return 1'b0;
    endfunction

    function automatic bpu_pred_pkg::score_t score_next(input bpu_pred_pkg::score_t s,
                                                        input logic hit);
        if (hit) begin
            return (s == 2'd1) ? 2'd0 : (s == 2'd2) ? 2'd3 : s;
        end
        return (s == 2'd0 || s == 2'd2) ? 2'd1 : 2'd2;
    endfunction

    task automatic train(input logic taken, input logic hit);
        if (taken) begin
            easy_lvl = (easy_lvl >= 2) ? 3 : 2;  // easy jumps straight across
            hard_lvl = (hard_lvl < 3) ? hard_lvl + 1 : 3;
        end else begin
            easy_lvl = (easy_lvl <= 1) ? 0 : 1;
            hard_lvl = (hard_lvl > 0) ? hard_lvl - 1 : 0;
        end
        m_score = score_next(m_score, hit);
        m_sel   = m_score[1] ? bpu_pred_pkg::SEL_EASY : bpu_pred_pkg::SEL_HARD;
    endtask

    task automatic mismatch(input string what, input logic [31:0] expv, input logic [31:0] actv);
        $display("[ERROR] %0s: %0s expected %h actual %h", test_name, what, expv, actv);
        errors++;
    endtask

    initial begin
        errors = 0;
    end

    always @(posedge clk) begin : model_step
        bpu_isa_pkg::btype_t bt;
        logic [INDEX_W-1:0]  fi;
        logic                tk;
        if (!rstn) begin
            m_valid   = '0;
            easy_lvl  = 2;
            hard_lvl  = 2;
            m_score   = '0;
            m_sel     = bpu_pred_pkg::SEL_IDLE;
            pend      = '0;
            exp_pred  = '0;
            exp_redir = 1'b0;
        end else begin
            bt = btype_of(fetch_inst);
            fi = fetch_pc[INDEX_W+2:3];
            tk = (bt == bpu_isa_pkg::BT_COND) ? cond_guess() : (bt != bpu_isa_pkg::BT_NONE);
            exp_pred.strobe = fetch_valid;
            exp_pred.taken  = tk;
            exp_pred.pc     = (tk && m_valid[fi]) ? m_tgt[fi] : fetch_pc + 32'd8;
            if (fetch_valid && bt == bpu_isa_pkg::BT_NONE) begin
                m_valid[fi] = 1'b0;
            end
            if (pend.strobe && pend.wr) begin  // after the clear, so it wins
                m_valid[pend.pc[INDEX_W+2:3]] = 1'b1;
                m_tgt[pend.pc[INDEX_W+2:3]]   = pend.target;
            end
            if (pend.strobe && pend.cond) begin
                train(pend.taken, pend.dir_hit);
            end
            pend.strobe  = resolve.strobe;
            pend.pc      = resolve.pc;
            pend.cond    = resolve.btype == bpu_isa_pkg::BT_COND;
            pend.taken   = resolve.taken;
            pend.dir_hit = resolve.pred_taken == resolve.taken;
            pend.wr      = resolve.taken && (resolve.pred_pc != resolve.target);
            pend.target  = resolve.target;
            exp_redir    = resolve.strobe && (!pend.dir_hit || pend.wr);
            exp_redir_pc = resolve.taken ? resolve.target : resolve.pc + 32'd8;
        end
    end

    // outputs settled half a cycle after the edge
    always @(negedge clk) begin
        if (rstn) begin
            if (pred.strobe !== exp_pred.strobe) begin
                mismatch("pred strobe", exp_pred.strobe, pred.strobe);
            end else if (exp_pred.strobe) begin
                if (pred.taken !== exp_pred.taken) begin
                    mismatch("pred taken", exp_pred.taken, pred.taken);
                end
                if (pred.pc !== exp_pred.pc) begin
                    mismatch("pred pc", exp_pred.pc, pred.pc);
                end
            end
            if (redirect_valid !== exp_redir) begin
                mismatch("redirect valid", exp_redir, redirect_valid);
            end else if (exp_redir && redirect_pc !== exp_redir_pc) begin
                mismatch("redirect pc", exp_redir_pc, redirect_pc);
            end
        end
    end

endmodule

// File: tests/bpu_properties.sv
`timescale 1ns/1ns

module bpu_properties (
    input logic                   clk,
    input logic                   rstn,
    input logic                   fetch_valid,
    input bpu_pred_pkg::resolve_s resolve,
    input bpu_pred_pkg::pred_s    pred,
    input logic                   redirect_valid,
    input bpu_isa_pkg::pc_t       redirect_pc
);

    int fail_count;  // read by the testbench at the end

    initial begin
        fail_count = 0;
    end

    pred_needs_fetch: assert property (
        @(posedge clk) disable iff (!rstn) pred.strobe |-> $past(fetch_valid)
    ) else begin
        fail_count++;
        $error("pred strobe without a fetch strobe one cycle earlier");
    end

    redirect_needs_resolve: assert property (
        @(posedge clk) disable iff (!rstn) redirect_valid |-> $past(resolve.strobe)
    ) else begin
        fail_count++;
        $error("redirect without a resolve strobe one cycle earlier");
    end

    // whole pred struct, strobe low included
    outputs_known: assert property (
        @(posedge clk) disable iff (!rstn) !$isunknown({pred, redirect_valid, redirect_pc})
    ) else begin
        fail_count++;
        $error("unknown value on a DUT output after reset");
    end

endmodule

// File: tests/bpu_tb.sv
`timescale 1ns/1ns

module bpu_tb;

    localparam int INDEX_W    = 8;
    localparam int CLK_PERIOD = 100;

    // cycles per test, three idle cycles at the end of each
    localparam int LEN_EMPTY = 15;
    localparam int LEN_JUMP  = 8;
    localparam int LEN_ALIAS = 8;
    localparam int LEN_COND  = 99;
    localparam int LEN_NT    = 19;
    localparam int LEN_MIX   = 203;
    localparam int WATCHDOG_NS =
        (2 + LEN_EMPTY + LEN_JUMP + LEN_ALIAS + LEN_COND + LEN_NT + LEN_MIX + 50) * CLK_PERIOD;

    logic                   clk;
    logic                   rstn;
    logic                   fetch_valid;
    bpu_isa_pkg::pc_t       fetch_pc;
    bpu_isa_pkg::inst_t     fetch_inst;
    bpu_pred_pkg::resolve_s resolve;
    bpu_pred_pkg::pred_s    pred;
    logic                   redirect_valid;
    bpu_isa_pkg::pc_t       redirect_pc;
    logic [95:0]            test_name;
    int                     errors;
    int                     errors_seen;
    int                     tests_done;
    logic [31:0]            rng;

    branch_predict_unit #(
        .INDEX_W (INDEX_W)
    ) i_branch_predict_unit (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .resolve        (resolve),
        .pred           (pred),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    bpu_checker #(
        .INDEX_W (INDEX_W)
    ) i_bpu_checker (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst),
        .resolve        (resolve),
        .pred           (pred),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .test_name      (test_name),
        .errors         (errors)
    );

    bind branch_predict_unit bpu_properties i_bpu_properties (
        .clk            (clk),
        .rstn           (rstn),
        .fetch_valid    (fetch_valid),
        .resolve        (resolve),
        .pred           (pred),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic bpu_isa_pkg::inst_t make_inst(input bpu_isa_pkg::btype_t bt);
        logic [31:0] r;
        r = next_rand();
        case (bt)
            bpu_isa_pkg::BT_JUMP:     return {bpu_isa_pkg::OPC_JUMP, r[27:0]};
            bpu_isa_pkg::BT_COND:     return {bpu_isa_pkg::OPC_COND, r[27:0]};
            bpu_isa_pkg::BT_INDIRECT: return {bpu_isa_pkg::OPC_INDIRECT, r[27:0]};
            default:                  return {1'b0, r[30:0]};  // opcodes 0..7
        endcase
    endfunction

    // eight indices, each with an aliasing twin one table span higher
    function automatic bpu_isa_pkg::pc_t mix_pc(input logic [3:0] sel);
        return 32'h0000_8000 + {sel[2:0], 3'b000} +
               (sel[3] ? (32'd1 << (INDEX_W + 3)) : 32'd0);
    endfunction

    task automatic drive(input logic fv, input bpu_isa_pkg::pc_t pc,
                         input bpu_isa_pkg::inst_t inst, input bpu_pred_pkg::resolve_s res);
        @(posedge clk);
        fetch_valid <= fv;
        fetch_pc    <= pc;
        fetch_inst  <= inst;
        resolve     <= res;
    endtask

    // fetch, then send the used prediction back with the real outcome
    task automatic branch_round(input bpu_isa_pkg::pc_t pc, input bpu_isa_pkg::btype_t bt,
                                input logic taken, input bpu_isa_pkg::pc_t target);
        bpu_pred_pkg::resolve_s res;
        drive(1'b1, pc, make_inst(bt), '0);
        drive(1'b0, pc, '0, '0);
        @(negedge clk);
        res            = '0;
        res.strobe     = 1'b1;
        res.pc         = pc;
        res.btype      = bt;
        res.taken      = taken;
        res.target     = target;
        res.pred_taken = pred.taken;
        res.pred_pc    = pred.pc;
        drive(1'b0, pc, '0, res);
        drive(1'b0, pc, '0, '0);
    endtask

    task automatic close_test();
        repeat (3) drive(1'b0, fetch_pc, '0, '0);
        tests_done++;
        $display("test %0s: %0d errors", test_name, errors - errors_seen);
        errors_seen = errors;
    endtask

    initial begin : stimulus
        logic [31:0]            r;
        bpu_isa_pkg::btype_t    bt;
        bpu_pred_pkg::resolve_s res;
        int                     assert_fails;
        clk         = 1'b0;
        rstn        = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst  = '0;
        resolve     = '0;
        test_name   = "reset";
        errors_seen = 0;
        tests_done  = 0;
        rng         = 32'd98;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        test_name = "empty_table";
        for (int i = 0; i < LEN_EMPTY - 3; i++) begin
            r  = next_rand();
            bt = (i % 3 == 0) ? bpu_isa_pkg::BT_COND :
                 (i % 3 == 1) ? bpu_isa_pkg::BT_NONE : bpu_isa_pkg::BT_JUMP;
            drive(1'b1, {16'h0, r[15:3], 3'b000}, make_inst(bt), '0);
        end
        close_test();

        test_name = "jump_target";
        branch_round(32'h0000_1000, bpu_isa_pkg::BT_JUMP, 1'b1, 32'h0000_2000);
        drive(1'b1, 32'h0000_1000, make_inst(bpu_isa_pkg::BT_JUMP), '0);
        close_test();

        test_name = "alias_clear";
        drive(1'b1, 32'h0000_1000 + (32'd1 << (INDEX_W + 3)),
              make_inst(bpu_isa_pkg::BT_NONE), '0);
        drive(1'b1, 32'h0000_1000, make_inst(bpu_isa_pkg::BT_JUMP), '0);
        // table write lands on the same edge as a clear at that index
        res            = '0;
        res.strobe     = 1'b1;
        res.pc         = 32'h0000_1000;
        res.btype      = bpu_isa_pkg::BT_JUMP;
        res.taken      = 1'b1;
        res.target     = 32'h0000_2400;
        res.pred_taken = 1'b1;
        res.pred_pc    = 32'h0000_1008;
        drive(1'b0, 32'h0000_1000, '0, res);
        drive(1'b1, 32'h0000_1000 + (32'd1 << (INDEX_W + 3)),
              make_inst(bpu_isa_pkg::BT_NONE), '0);
        drive(1'b1, 32'h0000_1000, make_inst(bpu_isa_pkg::BT_JUMP), '0);
        close_test();

        test_name = "cond_seq";
        for (int i = 0; i < 24; i++) begin  // taken, alternating, random
            r = next_rand();
            branch_round(32'h0000_3000, bpu_isa_pkg::BT_COND,
                         (i < 8) ? 1'b1 : (i < 16) ? i[0] : r[0], 32'h0000_3400);
        end
        close_test();

        test_name = "cond_not_tkn";
        for (int i = 0; i < 4; i++) begin
            branch_round(32'h0000_5000, bpu_isa_pkg::BT_COND, i < 3, 32'h0000_5200);
        end
        close_test();

        test_name = "random_mix";
        for (int i = 0; i < LEN_MIX - 3; i++) begin
            r              = next_rand();
            res            = '0;
            res.strobe     = r[4];
            res.pc         = mix_pc(r[8:5]);
            res.btype      = r[10:9];
            res.taken      = r[11];
            res.target     = 32'h0000_9000 + {r[15:12], 3'b000};
            res.pred_taken = r[16];
            res.pred_pc    = r[17] ? res.target : res.pc + 32'd8;
            drive(r[0], mix_pc(r[3:0]), make_inst(r[19:18]), res);
        end
        close_test();

        assert_fails = i_branch_predict_unit.i_bpu_properties.fail_count;
        $display("summary: %0d tests, %0d errors, %0d assertion failures",
                 tests_done, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
